// File: run.sh
#!/bin/sh
# compile and run the multi-h matched filter regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module mfiltTb \
   -Mdir obj_dir -f sim.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/VmfiltTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "Regression passed" sim.log; then
   exit 0
fi
exit 1

// File: sim.f
+incdir+source
+incdir+sim
source/mfiltPkg.sv
source/dsp48Mac.sv
source/sampleWindow.sv
source/tapSequencer.sv
source/coeffRom.sv
source/mfilt.sv
source/multiHFilter.sv
sim/mfiltTb.sv

// File: sim/mfiltModel.svh
/*
   reference model for the multi-h matched filter testbench
   coefficient mirror, sample line tracking and expected correlations
*/

`ifndef MFILT_MODEL_SVH
`define MFILT_MODEL_SVH

// four samples, entry 0 the oldest
typedef mfiltPkg::cplxT [`MF_TAPS-1:0] winT;

// expected direct and conjugate outputs of one symbol
typedef struct packed {
   mfiltPkg::mfOutT mf0;
   mfiltPkg::mfOutT mf1;
} mfPairT;

// ---------------------------------------------------------------------
// coefficient mirror in Q1.17, one row per set, taps 0 to 3
// ---------------------------------------------------------------------
localparam int COEF_I [16] = '{
    46341,  60547, 65536, 60547,
    25080,  54491, 65536, 54491,
        0,  46341, 65536, 46341,
   -25080,  36410, 65536, 36410
};
localparam int COEF_Q [16] = '{
   -46341, -25080, 0, 25080,
   -60547, -36410, 0, 36410,
   -65536, -46341, 0, 46341,
   -60547, -54491, 0, 54491
};

function automatic mfiltPkg::cplxT coeffOf(input logic [1:0] h, input logic [1:0] tap);
   mfiltPkg::cplxT c;
   int ci;
   int cq;
   ci = COEF_I[{h, tap}];
   cq = COEF_Q[{h, tap}];
   c.i = ci[`MF_SAMPLE_W-1:0];
   c.q = cq[`MF_SAMPLE_W-1:0];
   return c;
endfunction

// one step of the sample line, newest sample at the top
function automatic winT shiftIn(input winT w, input mfiltPkg::cplxT s);
   winT r;
   for (int k = 0; k < `MF_TAPS - 1; k++) begin
      r[k] = w[k+1];
   end
   r[`MF_TAPS-1] = s;
   return r;
endfunction

// ---------------------------------------------------------------------
// direct and conjugate correlation, top bits of the 36 bit sums
// ---------------------------------------------------------------------
function automatic mfPairT correlate(input winT w, input logic [1:0] h);
   mfiltPkg::cplxT c;
   longint sII, sQQ, sIQ, sQI;
   longint d0i, d0q, d1i, d1q;
   mfPairT res;
   sII = 0;
   sQQ = 0;
   sIQ = 0;
   sQI = 0;
   for (int k = 0; k < `MF_TAPS; k++) begin
      c = coeffOf(h, k[1:0]);
      sII += longint'($signed(w[k].i)) * longint'($signed(c.i));
      sQQ += longint'($signed(w[k].q)) * longint'($signed(c.q));
      sIQ += longint'($signed(w[k].i)) * longint'($signed(c.q));
      sQI += longint'($signed(w[k].q)) * longint'($signed(c.i));
   end
   // exact in 64 bits, low 36 bits match the modulo 2^36 sums
   d0i = sII - sQQ;
   d0q = sIQ + sQI;
   d1i = sII + sQQ;
   d1q = sQI - sIQ;
   res.mf0.i = d0i[`MF_ACC_W-1 -: `MF_OUT_W];
   res.mf0.q = d0q[`MF_ACC_W-1 -: `MF_OUT_W];
   res.mf1.i = d1i[`MF_ACC_W-1 -: `MF_OUT_W];
   res.mf1.q = d1q[`MF_ACC_W-1 -: `MF_OUT_W];
   return res;
endfunction

`endif

// File: sim/mfiltTb.sv
/*
   multi-h matched filter testbench
   LFSR samples at twice the symbol rate, reference model with fixed
   8 cycle latency, concurrent checks on the outputs and a watchdog
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module mfiltTb;

   localparam int SYMBOLS = 96;
   localparam int SYM_CYCLES = 12;
   localparam logic [`MF_SAMPLE_W-1:0] POS_FS = {1'b0, {(`MF_SAMPLE_W-1){1'b1}}};
   localparam logic [`MF_SAMPLE_W-1:0] NEG_FS = {1'b1, {(`MF_SAMPLE_W-1){1'b0}}};

   logic clk;
   logic reset;
   logic symEn;
   logic sym2xEn;
   mfiltPkg::cplxT sample;
   logic [$clog2(`MF_SETS)-1:0] hIndex;
   mfiltPkg::mfOutT mf0;
   mfiltPkg::mfOutT mf1;
   logic mfValid;

   `include "mfiltModel.svh"

   // model state updated on the rising edge from driven inputs
   winT line;
   mfPairT pending[$];
   int countdown;
   logic expValid;
   mfiltPkg::mfOutT expMf0;
   mfiltPkg::mfOutT expMf1;

   logic [31:0] lfsr;
   int validSeen = 0;
   int validErrs = 0;
   int mf0Errs = 0;
   int mf1Errs = 0;
   int holdErrs = 0;

   multiHFilter i_dut (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sym2xEn (sym2xEn),
      .sample  (sample),
      .hIndex  (hIndex),
      .mf0     (mf0),
      .mf1     (mf1),
      .mfValid (mfValid)
   );

   always #50 clk = ~clk;

   // ---------------------------------------------------------------------
   // stimulus helpers
   // ---------------------------------------------------------------------
   // galois LFSR stepped once per bit taken
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      r = '0;
      for (int b = 0; b < n; b++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'hD0000001 : 32'h0);
      end
      return r;
   endfunction

   // owner of sample n among the full scale symbols
   function automatic int windowOwner(input int n);
      int owner;
      owner = -1;
      for (int m = n / 2; m <= (n + 3) / 2; m++) begin
         if (m % 7 == 5 && 2 * m - 3 <= n && n <= 2 * m) owner = m;
      end
      return owner;
   endfunction

   // walks through all four sets
   function automatic logic [1:0] forcedSet(input int m);
      int s;
      s = (m / 7) % 4;
      return s[1:0];
   endfunction

   // signs follow the coefficients so the conjugate sum wraps
   function automatic mfiltPkg::cplxT fullScaleSample(input int m, input int n);
      mfiltPkg::cplxT c;
      mfiltPkg::cplxT s;
      int tap;
      logic flip;
      tap = n - (2 * m - 3);
      c = coeffOf(forcedSet(m), tap[1:0]);
      // negative full scale on alternate pairs
      flip = ((m / 14) % 2) == 1;
      s.i = (c.i[`MF_SAMPLE_W-1] ^ flip) ? NEG_FS : POS_FS;
      s.q = (c.q[`MF_SAMPLE_W-1] ^ flip) ? NEG_FS : POS_FS;
      return s;
   endfunction

   // ---------------------------------------------------------------------
   // reference model with the 8 cycle result latency
   // ---------------------------------------------------------------------
   always @(posedge clk) begin : refModel
      mfPairT pair;
      if (reset) begin
         line = '0;
         pending.delete();
         countdown <= 0;
         expValid <= 1'b0;
         expMf0 <= '0;
         expMf1 <= '0;
      end else begin
         expValid <= 1'b0;
         if (symEn) begin
            // window is the line before this cycle's shift
            pending.push_back(correlate(line, hIndex));
            countdown <= 7;
         end else if (countdown != 0) begin
            countdown <= countdown - 1;
            if (countdown == 1) begin
               pair = pending.pop_front();
               expValid <= 1'b1;
               expMf0 <= pair.mf0;
               expMf1 <= pair.mf1;
            end
         end
         if (sym2xEn) line = shiftIn(line, sample);
      end
   end

   always @(negedge clk) begin
      if (!reset && mfValid) validSeen++;
   end

   // ---------------------------------------------------------------------
   // checks on the falling edge where outputs are stable
   // ---------------------------------------------------------------------
   assert property (@(negedge clk) disable iff (reset) mfValid == expValid)
      else begin
         validErrs++;
         $display("error mfValid expected %h actual %h", expValid, mfValid);
      end

   assert property (@(negedge clk) disable iff (reset) mf0 == expMf0)
      else begin
         mf0Errs++;
         $display("error mf0 expected %h actual %h", expMf0, mf0);
      end

   assert property (@(negedge clk) disable iff (reset) mf1 == expMf1)
      else begin
         mf1Errs++;
         $display("error mf1 expected %h actual %h", expMf1, mf1);
      end

   // outputs move only together with mfValid
   assert property (@(negedge clk) disable iff (reset)
                    mfValid || (mf0 == $past(mf0) && mf1 == $past(mf1)))
      else begin
         holdErrs++;
         $display("mf0 or mf1 changed while mfValid was low");
      end

   // ---------------------------------------------------------------------
   // main sequence
   // ---------------------------------------------------------------------
   initial begin
      logic [31:0] rnd;
      int n;
      int owner;
      int totalErrs;
      clk = 1'b0;
      lfsr = 32'd2146;
      reset = 1'b1;
      symEn = 1'b0;
      sym2xEn = 1'b0;
      sample = '0;
      hIndex = '0;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      // idle stretch with outputs held at zero
      repeat (10) @(negedge clk);
      n = 0;
      for (int m = 0; m < SYMBOLS; m++) begin
         for (int c = 0; c < SYM_CYCLES; c++) begin
            sym2xEn = (c == 0) || (c == 6);
            symEn = (c == 6);
            // set index changes every cycle and only symEn takes it
            rnd = randBits(2);
            hIndex = rnd[1:0];
            if (symEn && m % 7 == 5) hIndex = forcedSet(m);
            owner = sym2xEn ? windowOwner(n) : -1;
            if (owner >= 0) begin
               sample = fullScaleSample(owner, n);
            end else begin
               rnd = randBits(`MF_SAMPLE_W);
               sample.i = rnd[`MF_SAMPLE_W-1:0];
               rnd = randBits(`MF_SAMPLE_W);
               sample.q = rnd[`MF_SAMPLE_W-1:0];
            end
            if (sym2xEn) n++;
            @(negedge clk);
         end
      end
      sym2xEn = 1'b0;
      symEn = 1'b0;
      // wait for the last results
      while (validSeen < SYMBOLS) @(negedge clk);
      repeat (SYM_CYCLES) @(negedge clk);
      totalErrs = validErrs + mf0Errs + mf1Errs + holdErrs;
      $display("symbols %0d, errors: valid %0d mf0 %0d mf1 %0d hold %0d total %0d",
               validSeen, validErrs, mf0Errs, mf1Errs, holdErrs, totalErrs);
      if (totalErrs == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // run length plus margin
   initial begin
      #((SYMBOLS * SYM_CYCLES + 200) * 100);
      $display("timeout, the results did not arrive in time");
      $display("Regression failed");
      $finish;
   end

endmodule

// File: source/coeffRom.sv
/*
   fixed matched filter coefficient table
   four complex sets of four taps, one set per modulation index
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module coeffRom (
   input  logic [$clog2(`MF_SETS)-1:0]  hSel,
   input  logic [$clog2(`MF_TAPS)-1:0]  tap,
   output mfiltPkg::cplxT               coeff
);

   // ---------------------------------------------------------------------
   // coefficient table, {I, Q} in Q1.17
   // ---------------------------------------------------------------------
   // tap 0 pairs with the oldest sample of the window
   always_comb begin
      case ({hSel, tap})
         // set 0, smallest index, slow phase walk
         4'h0: coeff = {18'sd46341, -18'sd46341};
         4'h1: coeff = {18'sd60547, -18'sd25080};
         4'h2: coeff = {18'sd65536, 18'sd0};
         4'h3: coeff = {18'sd60547, 18'sd25080};
         // set 1
         4'h4: coeff = {18'sd25080, -18'sd60547};
         4'h5: coeff = {18'sd54491, -18'sd36410};
         4'h6: coeff = {18'sd65536, 18'sd0};
         4'h7: coeff = {18'sd54491, 18'sd36410};
         // set 2
         4'h8: coeff = {18'sd0, -18'sd65536};
         4'h9: coeff = {18'sd46341, -18'sd46341};
         4'hA: coeff = {18'sd65536, 18'sd0};
         4'hB: coeff = {18'sd46341, 18'sd46341};
         // set 3, largest index, fastest phase walk
         4'hC: coeff = {-18'sd25080, -18'sd60547};
         4'hD: coeff = {18'sd36410, -18'sd54491};
         4'hE: coeff = {18'sd65536, 18'sd0};
         4'hF: coeff = {18'sd36410, 18'sd54491};
         default: coeff = '0;
      endcase
   end

endmodule

// File: source/dsp48Mac.sv
/*
   signed 18x18 multiply-accumulate slice
   registered product followed by a load-or-add accumulator
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module dsp48Mac (
   input  logic                        clk,
   input  logic                        reset,
   input  logic signed [`MF_SAMPLE_W-1:0] a,
   input  logic signed [`MF_SAMPLE_W-1:0] b,
   input  logic                        accEn,
   output logic signed [`MF_ACC_W-1:0]    p
);

   // product register, first pipe stage
   logic signed [`MF_ACC_W-1:0] prodR;
   // running sum
   logic signed [`MF_ACC_W-1:0] accR;

   always_ff @(posedge clk) begin
      if (reset) begin
         prodR <= '0;
         accR  <= '0;
      end else begin
         // full precision, 18x18 fits in 36 bits
         prodR <= a * b;
         // accEn low starts a new sum with the current product
         if (accEn) begin
            // wraps modulo 2^36
            accR <= accR + prodR;
         end else begin
            accR <= prodR;
         end
      end
   end

   assign p = accR;

endmodule

// File: source/mfilt.sv
/*
   multi-h matched filter core
   frozen sample window against a complex coefficient set, four shared MACs,
   direct and conjugate correlation with truncated registered outputs
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module mfilt #(
   parameter int MF_OUT_W_P = `MF_OUT_W
) (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           symEn,
   input  logic                           sym2xEn,
   input  mfiltPkg::cplxT                 sample,
   input  logic [$clog2(`MF_SETS)-1:0]    hIndex,
   input  mfiltPkg::cplxT                 coeff,
   output logic [$clog2(`MF_TAPS)-1:0]    tapSel,
   output logic [$clog2(`MF_SETS)-1:0]    hSel,
   output mfiltPkg::mfOutT                mf0,
   output mfiltPkg::mfOutT                mf1,
   output logic                           mfValid
);

   mfiltPkg::cplxT [`MF_TAPS-1:0] window;
   logic accEn;
   logic latchEn;

   // registered MAC operands
   mfiltPkg::cplxT dataR;
   mfiltPkg::cplxT coeffR;

   // cross product sums
   logic signed [`MF_ACC_W-1:0] macII, macQQ, macIQ, macQI;
   logic signed [`MF_ACC_W-1:0] sum0I, sum0Q, sum1I, sum1Q;

   // ---------------------------------------------------------------------
   // window and tap walk
   // ---------------------------------------------------------------------
   sampleWindow i_window (
      .clk     (clk),
      .reset   (reset),
      .sym2xEn (sym2xEn),
      .symEn   (symEn),
      .sample  (sample),
      .window  (window)
   );

   tapSequencer i_seq (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .tapSel  (tapSel),
      .accEn   (accEn),
      .latchEn (latchEn)
   );

   // set index follows the symbol, stays fixed over the walk
   always_ff @(posedge clk) begin
      if (reset) begin
         hSel <= '0;
      end else if (symEn) begin
         hSel <= hIndex;
      end
   end

   // sample and coefficient for the current tap
   always_ff @(posedge clk) begin
      dataR  <= window[tapSel];
      coeffR <= coeff;
   end

   // ---------------------------------------------------------------------
   // MAC slices, one per cross product
   // ---------------------------------------------------------------------
   dsp48Mac i_macII (
      .clk (clk), .reset (reset), .a (dataR.i), .b (coeffR.i),
      .accEn (accEn), .p (macII)
   );

   dsp48Mac i_macQQ (
      .clk (clk), .reset (reset), .a (dataR.q), .b (coeffR.q),
      .accEn (accEn), .p (macQQ)
   );

   dsp48Mac i_macIQ (
      .clk (clk), .reset (reset), .a (dataR.i), .b (coeffR.q),
      .accEn (accEn), .p (macIQ)
   );

   dsp48Mac i_macQI (
      .clk (clk), .reset (reset), .a (dataR.q), .b (coeffR.i),
      .accEn (accEn), .p (macQI)
   );

   // ---------------------------------------------------------------------
   // combiner
   // ---------------------------------------------------------------------
   // direct, s * c
   assign sum0I = macII - macQQ;
   assign sum0Q = macIQ + macQI;
   // conjugate, s * conj(c)
   assign sum1I = macII + macQQ;
   assign sum1Q = macQI - macIQ;

   // keep the top bits only, held until the next symbol
   always_ff @(posedge clk) begin
      if (reset) begin
         mf0     <= '0;
         mf1     <= '0;
         mfValid <= 1'b0;
      end else begin
         mfValid <= latchEn;
         if (latchEn) begin
            mf0.i <= sum0I[`MF_ACC_W-1 -: MF_OUT_W_P];
            mf0.q <= sum0Q[`MF_ACC_W-1 -: MF_OUT_W_P];
            mf1.i <= sum1I[`MF_ACC_W-1 -: MF_OUT_W_P];
            mf1.q <= sum1Q[`MF_ACC_W-1 -: MF_OUT_W_P];
         end
      end
   end

endmodule

// File: source/mfiltPkg.sv
/*
   multi-h matched filter types
   complex sample, complex output pair and tap walker states
*/

`include "mfilt_defines.svh"

package mfiltPkg;

   // ---------------------------------------------------------------------
   // complex baseband sample, also used for coefficients
   // ---------------------------------------------------------------------
   typedef struct packed {
      logic signed [`MF_SAMPLE_W-1:0] i;
      logic signed [`MF_SAMPLE_W-1:0] q;
   } cplxT;

   // truncated matched filter output, one per correlator
   typedef struct packed {
      logic signed [`MF_OUT_W-1:0] i;
      logic signed [`MF_OUT_W-1:0] q;
   } mfOutT;

   // ---------------------------------------------------------------------
   // tap walker states
   // ---------------------------------------------------------------------
   typedef enum logic [2:0] {
      IDLE,
      TAP0,
      TAP1,
      TAP2,
      TAP3,
      DRAIN
   } tapStateT;

endpackage

// File: source/mfilt_defines.svh
/*
   multi-h matched filter widths and sizes
   shared by the filter RTL, its package and the testbench
*/

`ifndef MFILT_DEFINES_SVH
`define MFILT_DEFINES_SVH

// I/Q sample and coefficient component width
`define MF_SAMPLE_W 18

// product and accumulator width, full 18x18 result
`define MF_ACC_W 36

// default width of each truncated output component
`define MF_OUT_W 10

// taps per symbol, two symbols at two samples each
`define MF_TAPS 4

// number of coefficient sets, one per modulation index
`define MF_SETS 4

`endif

// File: source/multiHFilter.sv
/*
   multi-h matched filter top
   filter core with its fixed coefficient table
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module multiHFilter (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           symEn,
   input  logic                           sym2xEn,
   input  mfiltPkg::cplxT                 sample,
   input  logic [$clog2(`MF_SETS)-1:0]    hIndex,
   output mfiltPkg::mfOutT                mf0,
   output mfiltPkg::mfOutT                mf1,
   output logic                           mfValid
);

   // table lookup driven by the core
   logic [$clog2(`MF_TAPS)-1:0] tapSel;
   logic [$clog2(`MF_SETS)-1:0] hSel;
   mfiltPkg::cplxT coeff;

   mfilt i_core (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sym2xEn (sym2xEn),
      .sample  (sample),
      .hIndex  (hIndex),
      .coeff   (coeff),
      .tapSel  (tapSel),
      .hSel    (hSel),
      .mf0     (mf0),
      .mf1     (mf1),
      .mfValid (mfValid)
   );

   // combinational answer, registered inside the core
   coeffRom i_rom (
      .hSel  (hSel),
      .tap   (tapSel),
      .coeff (coeff)
   );

endmodule

// File: source/sampleWindow.sv
/*
   sample window for the matched filter
   shift line stepped at twice the symbol rate, snapshot frozen per symbol
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module sampleWindow (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                sym2xEn,
   input  logic                                symEn,
   input  mfiltPkg::cplxT                      sample,
   output mfiltPkg::cplxT [`MF_TAPS-1:0]       window
);

   // ---------------------------------------------------------------------
   // shift line, entry 0 is the oldest sample
   // ---------------------------------------------------------------------
   mfiltPkg::cplxT [`MF_TAPS-1:0] line;

   always_ff @(posedge clk) begin
      if (reset) begin
         line <= '0;
      end else if (sym2xEn) begin
         // older samples move toward entry 0
         for (int k = 0; k < `MF_TAPS - 1; k++) begin
            line[k] <= line[k+1];
         end
         // newest sample enters at the top
         line[`MF_TAPS-1] <= sample;
      end
   end

   // ---------------------------------------------------------------------
   // snapshot register
   // ---------------------------------------------------------------------
   // takes the line before this cycle's shift, so the window holds
   // the four samples that precede the current one
   always_ff @(posedge clk) begin
      if (reset) begin
         window <= '0;
      end else if (symEn) begin
         // held stable over the whole tap walk
         window <= line;
      end
   end

endmodule

// File: source/tapSequencer.sv
/*
   per-symbol tap walker
   steps the four taps after symEn, lines up the accumulate enable with
   the MAC pipeline and pulses the result latch once per symbol
*/

`timescale 1ns/1ps

`include "mfilt_defines.svh"

module tapSequencer (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           symEn,
   output logic [$clog2(`MF_TAPS)-1:0]    tapSel,
   output logic                           accEn,
   output logic                           latchEn
);

   mfiltPkg::tapStateT state;
   mfiltPkg::tapStateT nextState;

   // accumulate flag, two stages behind the tap state
   logic [1:0] accDly;
   // last tap marker, three stages behind the tap state
   logic [2:0] lastDly;
   // taps that add onto the running sum
   logic addTap;

   assign addTap = (state == mfiltPkg::TAP1) ||
                   (state == mfiltPkg::TAP2) ||
                   (state == mfiltPkg::TAP3);

   // ---------------------------------------------------------------------
   // next state
   // ---------------------------------------------------------------------
   always_comb begin
      nextState = state;
      // a new symbol always restarts the walk
      if (symEn) begin
         nextState = mfiltPkg::TAP0;
      end else begin
         case (state)
            mfiltPkg::IDLE:  nextState = mfiltPkg::IDLE;
            mfiltPkg::TAP0:  nextState = mfiltPkg::TAP1;
            mfiltPkg::TAP1:  nextState = mfiltPkg::TAP2;
            mfiltPkg::TAP2:  nextState = mfiltPkg::TAP3;
            mfiltPkg::TAP3:  nextState = mfiltPkg::DRAIN;
            // wait for the last product to reach the sum
            mfiltPkg::DRAIN: if (lastDly[2]) nextState = mfiltPkg::IDLE;
            default:         nextState = mfiltPkg::IDLE;
         endcase
      end
   end

   // ---------------------------------------------------------------------
   // state and pipeline alignment
   // ---------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= mfiltPkg::IDLE;
         accDly  <= '0;
         lastDly <= '0;
      end else begin
         state <= nextState;
         if (symEn) begin
            // drop anything left over from an aborted walk
            accDly  <= '0;
            lastDly <= '0;
         end else begin
            accDly  <= {accDly[0], addTap};
            lastDly <= {lastDly[1:0], (state == mfiltPkg::TAP3)};
         end
      end
   end

   // tap index straight from the state
   always_comb begin
      case (state)
         mfiltPkg::TAP1: tapSel = 2'd1;
         mfiltPkg::TAP2: tapSel = 2'd2;
         mfiltPkg::TAP3: tapSel = 2'd3;
         default:        tapSel = 2'd0;
      endcase
   end

   // operand reg plus product reg puts the add two cycles behind the tap
   assign accEn   = accDly[1];
   // sums complete, hand over to the combiner
   assign latchEn = lastDly[2];

endmodule
